// ==== files.f ====
verilog/lc3b_types.sv
verilog/lc3b_pipe_types.sv
verilog/instr_decoder.sv
verilog/regfile.sv
verilog/forwarding_controller.sv
verilog/execute_stage.sv
verilog/retire_stage.sv
verilog/lc3b_exec_pipe.sv
tests/tb_exec_pipe.sv

// ==== tests/tb_exec_pipe.sv ====
`timescale 1ns/1ps

module tb_exec_pipe;

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    lc3b_types::lc3b_word instr;
    logic                 wb_valid;
    lc3b_types::lc3b_reg  wb_dest;
    lc3b_types::lc3b_word wb_data;
    lc3b_types::lc3b_nzp  cc;

    // architectural register copy, updated in program order at issue
    lc3b_types::lc3b_word arch_regs [lc3b_types::num_regs];

    // expected {dest, data, nzp} per retiring instruction
    logic [21:0] expected_q [$];

    logic [31:0] lcg_state;
    int          value_errors;
    int          protocol_errors;
    int          issued;
    int          retired;

    lc3b_exec_pipe i_dut (
        .clk, .rst, .instr_valid, .instr,
        .wb_valid, .wb_dest, .wb_data, .cc
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic is_supported(input logic [3:0] op);
        return (op == lc3b_types::op_add) || (op == lc3b_types::op_and) ||
               (op == lc3b_types::op_not);
    endfunction

    // ISA encoding, NOT forces bits 5:0 to all ones
    function automatic lc3b_types::lc3b_word make_instr(input logic [3:0] op,
            input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg sr1,
            input logic mode, input logic [4:0] low5);
        if (op == lc3b_types::op_not) begin
            return {op, dr, sr1, 6'h3f};
        end
        return {op, dr, sr1, mode, low5};
    endfunction

    // sequential execution of one instruction against arch_regs
    function automatic logic [21:0] ref_exec(input lc3b_types::lc3b_word ins);
        lc3b_types::lc3b_word a;
        lc3b_types::lc3b_word b;
        lc3b_types::lc3b_word r;
        lc3b_types::lc3b_nzp  flags;
        a = arch_regs[ins[8:6]];
        // imm5 sign extended by hand, register mode reads SR2
        b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : arch_regs[ins[2:0]];
        case (ins[15:12])
            lc3b_types::op_and: r = a & b;
            lc3b_types::op_not: r = ~a;
            default: r = a + b;
        endcase
        arch_regs[ins[11:9]] = r;
        flags = r[15] ? 3'b100 : ((r == 16'h0000) ? 3'b010 : 3'b001);
        return {ins[11:9], r, flags};
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
            input logic [15:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // one slot of stimulus; bubbles and unknown opcodes expect no writeback
    task automatic issue(input logic valid, input lc3b_types::lc3b_word ins);
        @(posedge clk);
        instr_valid <= valid;
        instr       <= ins;
        if (valid && is_supported(ins[15:12])) begin
            expected_q.push_back(ref_exec(ins));
            issued++;
        end
    endtask

    // scoreboard, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        logic [21:0] exp;
        if (rst) begin
            check_value("wb_valid", 16'h0, {15'h0, wb_valid});
            check_value("cc", 16'h2, {13'h0, cc});
        end else if (wb_valid) begin
            if (expected_q.size() == 0) begin
                protocol_errors++;
                $display("%0t ns: writeback seen with no instruction outstanding", $time);
            end else begin
                exp = expected_q.pop_front();
                check_value("wb_dest", {13'h0, exp[21:19]}, {13'h0, wb_dest});
                check_value("wb_data", exp[18:3], wb_data);
                check_value("cc", {13'h0, exp[2:0]}, {13'h0, cc});
            end
            retired++;
        end
    end

    initial begin
        logic [31:0]          r;
        logic [3:0]           op;
        logic                 valid;
        int                   wait_cycles;
        lc3b_types::lc3b_word ins;
        lcg_state       = 32'hbb7d_446d;
        value_errors    = 0;
        protocol_errors = 0;
        issued          = 0;
        retired         = 0;
        rst             = 1'b1;
        instr_valid     = 1'b0;
        instr           = '0;
        for (int i = 0; i < lc3b_types::num_regs; i++) begin
            arch_regs[i] = '0;
        end
        // reset over three rising edges
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("cc", 16'h2, {13'h0, cc});
        // NOT of zero register gives ffff, negative
        issue(1'b1, make_instr(lc3b_types::op_not, 3'd1, 3'd0, 1'b1, 5'h1f));
        // back to back, EX/MEM on both operands
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd1, 3'd1, 1'b1, 5'd5));
        issue(1'b1, make_instr(lc3b_types::op_and, 3'd4, 3'd1, 1'b0, 5'd1));
        // distance two, bubble between
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd5, 3'd1, 1'b1, 5'd2));
        issue(1'b0, '0);
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd6, 3'd5, 1'b0, 5'd5));
        // distance three, write-through in the register file
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd7, 3'd6, 1'b1, 5'h1f));
        issue(1'b1, make_instr(lc3b_types::op_not, 3'd2, 3'd2, 1'b1, 5'h1f));
        issue(1'b0, '0);
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd0, 3'd7, 1'b0, 5'd1));
        // two writes to R3, the reader must see the second
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd3, 3'd1, 1'b1, 5'd1));
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd3, 3'd1, 1'b1, 5'd6));
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd4, 3'd3, 1'b0, 5'd3));
        // negative immediates
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd5, 3'd4, 1'b1, 5'h10));
        // R2 is all ones, so the upper immediate bits show in the result
        issue(1'b1, make_instr(lc3b_types::op_and, 3'd6, 3'd2, 1'b1, 5'h1e));
        // imm bits 2:0 name R6, just written, must stay an immediate
        issue(1'b1, make_instr(lc3b_types::op_add, 3'd7, 3'd1, 1'b1, 5'h06));
        // random stream with bubbles and unknown opcodes
        for (int n = 0; n < 400; n++) begin
            r     = next_random();
            valid = 1'b1;
            case (r[27:26])
                2'd1: op = lc3b_types::op_and;
                2'd2: op = lc3b_types::op_not;
                default: op = lc3b_types::op_add;
            endcase
            if (r[31:28] < 4'd2) begin
                valid = 1'b0;
            end else if (r[31:28] < 4'd4) begin
                op = r[3:0];
            end
            ins = make_instr(op, r[22:20], r[19:17], r[16], r[15:11]);
            issue(valid, ins);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        // drain, bounded
        wait_cycles = 0;
        while ((expected_q.size() > 0) && (wait_cycles < 20)) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (expected_q.size() > 0) begin
            protocol_errors++;
            $display("timed out with %0d writebacks still missing", expected_q.size());
        end
        // idle cycles to catch stray writebacks
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
        end
        check_value("retired_count", issued[15:0], retired[15:0]);
        $display("errors: %0d value, %0d protocol (%0d issued, %0d retired)",
                 value_errors, protocol_errors, issued, retired);
        if ((value_errors == 0) && (protocol_errors == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_exec_pipe

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 id_ex_load,
    input  lc3b_types::lc3b_reg                  id_ex_dest,
    input  lc3b_pipe_types::lc3b_aluop           id_ex_aluop,
    input  logic                                 id_ex_use_imm,
    input  lc3b_types::lc3b_imm5                 id_ex_imm,
    input  lc3b_types::lc3b_word                 id_ex_sr1_data,
    input  lc3b_types::lc3b_word                 id_ex_sr2_data,
    input  lc3b_pipe_types::lc3b_forward_mux_sel forward_a_mux_sel,
    input  lc3b_pipe_types::lc3b_forward_mux_sel forward_b_mux_sel,
    input  lc3b_types::lc3b_word                 mem_wb_data,
    output logic                                 ex_mem_load,
    output lc3b_types::lc3b_reg                  ex_mem_dest,
    output lc3b_types::lc3b_word                 ex_mem_data
);

    // forwarded operands
    lc3b_types::lc3b_word fwd_a;
    lc3b_types::lc3b_word fwd_b;

    // final ALU inputs and result
    lc3b_types::lc3b_word imm_sext;
    lc3b_types::lc3b_word alu_b;
    lc3b_types::lc3b_word alu_out;

    // operand A source
    always_comb begin
        case (forward_a_mux_sel)
            lc3b_pipe_types::lc3b_forward_mux_sel_stage_MEM_regfile_data: fwd_a = ex_mem_data;
            lc3b_pipe_types::lc3b_forward_mux_sel_stage_WB_regfile_data:  fwd_a = mem_wb_data;
            default: fwd_a = id_ex_sr1_data;
        endcase
    end

    // operand B source
    always_comb begin
        case (forward_b_mux_sel)
            lc3b_pipe_types::lc3b_forward_mux_sel_stage_MEM_regfile_data: fwd_b = ex_mem_data;
            lc3b_pipe_types::lc3b_forward_mux_sel_stage_WB_regfile_data:  fwd_b = mem_wb_data;
            default: fwd_b = id_ex_sr2_data;
        endcase
    end

    // imm5 sign extension, replaces B in immediate mode
    assign imm_sext = {{11{id_ex_imm[4]}}, id_ex_imm};
    assign alu_b    = id_ex_use_imm ? imm_sext : fwd_b;

    // ALU
    always_comb begin
        case (id_ex_aluop)
            lc3b_pipe_types::alu_and: alu_out = fwd_a & alu_b;
            lc3b_pipe_types::alu_not: alu_out = ~fwd_a;
            default: alu_out = fwd_a + alu_b;
        endcase
    end

    // EX/MEM valid bit, a bubble passes through as load low
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_load <= 1'b0;
        end else begin
            ex_mem_load <= id_ex_load;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        ex_mem_dest <= id_ex_dest;
        ex_mem_data <= alu_out;
    end

endmodule : execute_stage

// ==== verilog/forwarding_controller.sv ====
`timescale 1ns/1ps

module forwarding_controller (
    input  lc3b_types::lc3b_reg                  id_ex_sr1,
    input  lc3b_types::lc3b_reg                  id_ex_sr2,
    input  logic                                 id_ex_requires_sr1,
    input  logic                                 id_ex_requires_sr2,
    input  logic                                 ex_mem_load,
    input  lc3b_types::lc3b_reg                  ex_mem_dest,
    input  logic                                 mem_wb_load,
    input  lc3b_types::lc3b_reg                  mem_wb_dest,
    output lc3b_pipe_types::lc3b_forward_mux_sel forward_a_mux_sel,
    output lc3b_pipe_types::lc3b_forward_mux_sel forward_b_mux_sel
);

    // hits against the instruction one slot ahead
    logic mem_hit_sr1;
    logic mem_hit_sr2;

    // hits against the instruction two slots ahead
    logic wb_hit_sr1;
    logic wb_hit_sr2;

    assign mem_hit_sr1 = ex_mem_load && id_ex_requires_sr1 && (id_ex_sr1 == ex_mem_dest);
    assign mem_hit_sr2 = ex_mem_load && id_ex_requires_sr2 && (id_ex_sr2 == ex_mem_dest);
    assign wb_hit_sr1  = mem_wb_load && id_ex_requires_sr1 && (id_ex_sr1 == mem_wb_dest);
    assign wb_hit_sr2  = mem_wb_load && id_ex_requires_sr2 && (id_ex_sr2 == mem_wb_dest);

    // EX/MEM checked first, it holds the newer value
    always_comb begin
        if (mem_hit_sr1) begin
            forward_a_mux_sel = lc3b_pipe_types::lc3b_forward_mux_sel_stage_MEM_regfile_data;
        end else if (wb_hit_sr1) begin
            forward_a_mux_sel = lc3b_pipe_types::lc3b_forward_mux_sel_stage_WB_regfile_data;
        end else begin
            forward_a_mux_sel = lc3b_pipe_types::lc3b_forward_mux_sel_pass;
        end
    end

    // same rule for the second source
    // requires_sr2 is low in immediate mode, so imm ops never forward here
    always_comb begin
        if (mem_hit_sr2) begin
            forward_b_mux_sel = lc3b_pipe_types::lc3b_forward_mux_sel_stage_MEM_regfile_data;
        end else if (wb_hit_sr2) begin
            forward_b_mux_sel = lc3b_pipe_types::lc3b_forward_mux_sel_stage_WB_regfile_data;
        end else begin
            forward_b_mux_sel = lc3b_pipe_types::lc3b_forward_mux_sel_pass;
        end
    end

endmodule : forwarding_controller

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instr_valid,
    input  lc3b_types::lc3b_word       instr,
    input  lc3b_types::lc3b_word       rf_sr1_data,
    input  lc3b_types::lc3b_word       rf_sr2_data,
    output lc3b_types::lc3b_reg        rf_sr1,
    output lc3b_types::lc3b_reg        rf_sr2,
    output logic                       id_ex_load,
    output lc3b_types::lc3b_reg        id_ex_dest,
    output lc3b_types::lc3b_reg        id_ex_sr1,
    output lc3b_types::lc3b_reg        id_ex_sr2,
    output logic                       id_ex_requires_sr1,
    output logic                       id_ex_requires_sr2,
    output lc3b_pipe_types::lc3b_aluop id_ex_aluop,
    output logic                       id_ex_use_imm,
    output lc3b_types::lc3b_imm5       id_ex_imm,
    output lc3b_types::lc3b_word       id_ex_sr1_data,
    output lc3b_types::lc3b_word       id_ex_sr2_data
);

    // raw instruction fields
    lc3b_types::lc3b_opcode opcode;
    lc3b_types::lc3b_reg    dest;
    lc3b_types::lc3b_imm5   imm;
    logic                   mode;

    // decoded controls
    logic                       supported;
    lc3b_pipe_types::lc3b_aluop aluop;
    logic                       needs_sr2;
    logic                       use_imm;

    assign opcode = lc3b_types::lc3b_opcode'(instr[15:12]);
    assign dest   = instr[11:9];
    assign mode   = instr[5];
    assign imm    = instr[4:0];

    // register file read addresses, straight from the instruction
    assign rf_sr1 = instr[8:6];
    assign rf_sr2 = instr[2:0];

    // opcode to ALU function
    always_comb begin
        supported = 1'b1;
        aluop     = lc3b_pipe_types::alu_add;
        case (opcode)
            lc3b_types::op_add: aluop = lc3b_pipe_types::alu_add;
            lc3b_types::op_and: aluop = lc3b_pipe_types::alu_and;
            lc3b_types::op_not: aluop = lc3b_pipe_types::alu_not;
            default: supported = 1'b0;
        endcase
    end

    // NOT has bits 5:0 all ones, so mode must be masked for it
    assign needs_sr2 = supported && (opcode != lc3b_types::op_not) && !mode;
    assign use_imm   = (opcode != lc3b_types::op_not) && mode;

    // ID/EX control bits
    // bubble on low valid or unknown opcode
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex_load         <= 1'b0;
            id_ex_requires_sr1 <= 1'b0;
            id_ex_requires_sr2 <= 1'b0;
        end else begin
            id_ex_load         <= instr_valid && supported;
            id_ex_requires_sr1 <= instr_valid && supported;
            id_ex_requires_sr2 <= instr_valid && needs_sr2;
        end
    end

    // ID/EX payload, only meaningful with id_ex_load
    always_ff @(posedge clk) begin
        id_ex_dest     <= dest;
        id_ex_sr1      <= rf_sr1;
        id_ex_sr2      <= rf_sr2;
        id_ex_aluop    <= aluop;
        id_ex_use_imm  <= use_imm;
        id_ex_imm      <= imm;
        // read data already includes the write-through from WB
        id_ex_sr1_data <= rf_sr1_data;
        id_ex_sr2_data <= rf_sr2_data;
    end

endmodule : instr_decoder

// ==== verilog/lc3b_exec_pipe.sv ====
`timescale 1ns/1ps

module lc3b_exec_pipe (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  lc3b_types::lc3b_word instr,
    output logic                 wb_valid,
    output lc3b_types::lc3b_reg  wb_dest,
    output lc3b_types::lc3b_word wb_data,
    output lc3b_types::lc3b_nzp  cc
);

    // register file read side
    lc3b_types::lc3b_reg  rf_sr1;
    lc3b_types::lc3b_reg  rf_sr2;
    lc3b_types::lc3b_word rf_sr1_data;
    lc3b_types::lc3b_word rf_sr2_data;

    // ID/EX barrier
    logic                       id_ex_load;
    lc3b_types::lc3b_reg        id_ex_dest;
    lc3b_types::lc3b_reg        id_ex_sr1;
    lc3b_types::lc3b_reg        id_ex_sr2;
    logic                       id_ex_requires_sr1;
    logic                       id_ex_requires_sr2;
    lc3b_pipe_types::lc3b_aluop id_ex_aluop;
    logic                       id_ex_use_imm;
    lc3b_types::lc3b_imm5       id_ex_imm;
    lc3b_types::lc3b_word       id_ex_sr1_data;
    lc3b_types::lc3b_word       id_ex_sr2_data;

    // forwarding selects
    lc3b_pipe_types::lc3b_forward_mux_sel forward_a_mux_sel;
    lc3b_pipe_types::lc3b_forward_mux_sel forward_b_mux_sel;

    // EX/MEM and MEM/WB barriers
    logic                 ex_mem_load;
    lc3b_types::lc3b_reg  ex_mem_dest;
    lc3b_types::lc3b_word ex_mem_data;
    logic                 mem_wb_load;
    lc3b_types::lc3b_reg  mem_wb_dest;
    lc3b_types::lc3b_word mem_wb_data;

    instr_decoder i_decoder (
        .clk, .rst, .instr_valid, .instr,
        .rf_sr1_data, .rf_sr2_data, .rf_sr1, .rf_sr2,
        .id_ex_load, .id_ex_dest, .id_ex_sr1, .id_ex_sr2,
        .id_ex_requires_sr1, .id_ex_requires_sr2, .id_ex_aluop,
        .id_ex_use_imm, .id_ex_imm, .id_ex_sr1_data, .id_ex_sr2_data
    );

    // written from MEM/WB, read from ID
    regfile i_regfile (
        .clk, .rst,
        .load (mem_wb_load), .dest (mem_wb_dest), .data (mem_wb_data),
        .sr1 (rf_sr1), .sr2 (rf_sr2),
        .sr1_data (rf_sr1_data), .sr2_data (rf_sr2_data)
    );

    forwarding_controller i_fwd_ctrl (
        .id_ex_sr1, .id_ex_sr2, .id_ex_requires_sr1, .id_ex_requires_sr2,
        .ex_mem_load, .ex_mem_dest, .mem_wb_load, .mem_wb_dest,
        .forward_a_mux_sel, .forward_b_mux_sel
    );

    execute_stage i_execute (
        .clk, .rst, .id_ex_load, .id_ex_dest, .id_ex_aluop,
        .id_ex_use_imm, .id_ex_imm, .id_ex_sr1_data, .id_ex_sr2_data,
        .forward_a_mux_sel, .forward_b_mux_sel, .mem_wb_data,
        .ex_mem_load, .ex_mem_dest, .ex_mem_data
    );

    retire_stage i_retire (
        .clk, .rst, .ex_mem_load, .ex_mem_dest, .ex_mem_data,
        .mem_wb_load, .mem_wb_dest, .mem_wb_data, .cc
    );

    // retirement port is the MEM/WB barrier itself
    assign wb_valid = mem_wb_load;
    assign wb_dest  = mem_wb_dest;
    assign wb_data  = mem_wb_data;

endmodule : lc3b_exec_pipe

// ==== verilog/lc3b_pipe_types.sv ====
package lc3b_pipe_types;

    // operand source for EX
    // pass takes the value latched from the register file in ID
    typedef enum logic [1:0] {
        lc3b_forward_mux_sel_pass                  = 2'b00,
        lc3b_forward_mux_sel_stage_MEM_regfile_data = 2'b01,
        lc3b_forward_mux_sel_stage_WB_regfile_data  = 2'b10
    } lc3b_forward_mux_sel;

    // ALU function
    // alu_not only looks at operand A
    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_and = 2'b01,
        alu_not = 2'b10
    } lc3b_aluop;

endpackage : lc3b_pipe_types

// ==== verilog/lc3b_types.sv ====
package lc3b_types;

    // architectural register count
    localparam int num_regs = 8;

    // 16-bit data word, instructions and register values
    typedef logic [15:0] lc3b_word;

    // register index, R0..R7
    typedef logic [2:0] lc3b_reg;

    // immediate field of ADD/AND, two's complement
    typedef logic [4:0] lc3b_imm5;

    // condition codes, n at bit 2, z at bit 1, p at bit 0
    typedef logic [2:0] lc3b_nzp;

    // instr[15:12]
    // only the ALU ops are handled by this core
    typedef enum logic [3:0] {
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_not = 4'b1001
    } lc3b_opcode;

endpackage : lc3b_types

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word data,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word sr1_data,
    output lc3b_types::lc3b_word sr2_data
);

    // R0..R7
    lc3b_types::lc3b_word regs [lc3b_types::num_regs];

    // write port, fed from MEM/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < lc3b_types::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= data;
        end
    end

    // combinational reads
    // a write in this cycle shows up on the read port right away,
    // which covers an instruction three slots behind its producer
    always_comb begin
        if (load && (dest == sr1)) begin
            sr1_data = data;
        end else begin
            sr1_data = regs[sr1];
        end
        if (load && (dest == sr2)) begin
            sr2_data = data;
        end else begin
            sr2_data = regs[sr2];
        end
    end

endmodule : regfile

// ==== verilog/retire_stage.sv ====
`timescale 1ns/1ps

module retire_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_mem_load,
    input  lc3b_types::lc3b_reg  ex_mem_dest,
    input  lc3b_types::lc3b_word ex_mem_data,
    output logic                 mem_wb_load,
    output lc3b_types::lc3b_reg  mem_wb_dest,
    output lc3b_types::lc3b_word mem_wb_data,
    output lc3b_types::lc3b_nzp  cc
);

    // flags of the result entering MEM/WB
    lc3b_types::lc3b_nzp nzp_next;

    // sign and zero test
    always_comb begin
        if (ex_mem_data[15]) begin
            nzp_next = 3'b100;
        end else if (ex_mem_data == '0) begin
            nzp_next = 3'b010;
        end else begin
            nzp_next = 3'b001;
        end
    end

    // no memory access in this core, MEM/WB is a straight copy of EX/MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb_load <= 1'b0;
        end else begin
            mem_wb_load <= ex_mem_load;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_dest <= ex_mem_dest;
        mem_wb_data <= ex_mem_data;
    end

    // cc moves together with wb_valid
    // resets to z, held across bubbles
    always_ff @(posedge clk) begin
        if (rst) begin
            cc <= 3'b010;
        end else if (ex_mem_load) begin
            cc <= nzp_next;
        end
    end

endmodule : retire_stage
